// File: frame_buffer.f
logic/frame_buffer_pkg.sv
logic/frame_ram.sv
logic/stream_to_mem.sv
logic/mem_to_stream.sv
logic/transfer_sequencer.sv
logic/frame_buffer_top.sv
testbench/frame_buffer_chk.sv
testbench/frame_buffer_tb.sv

// File: Makefile
# Verilator build, run and lint for the frame buffer

VERILATOR  ?= verilator
TOP        ?= frame_buffer_tb
RTL_TOP    ?= frame_buffer_top
FILELIST   ?= frame_buffer.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= >>> PASS
RTL_FILES  ?= logic/frame_buffer_pkg.sv logic/frame_ram.sv logic/stream_to_mem.sv \
              logic/mem_to_stream.sv logic/transfer_sequencer.sv logic/frame_buffer_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides the result, not the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF '$(PASS_TEXT)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/frame_buffer_tb.sv
`timescale 1ns/100ps

module frame_buffer_tb
    import frame_buffer_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int TIMEOUT_CYCLES = 5000;

    logic  clk;
    logic  reset;
    size_t in_size;
    logic  init_write;
    logic  write_ready;
    logic  read_ready;
    size_t out_size;
    data_t in_tdata;
    logic  in_tvalid;
    logic  in_tready;
    data_t out_tdata;
    logic  out_tvalid;
    logic  out_tlast;
    logic  out_tready;

    int    seed = 32'h2009_1ea6;
    // frame the buffer should hold
    data_t model [FRAME_DEPTH];
    int    model_len;

    frame_buffer_top u_frame_buffer_top (
        .clk         (clk),
        .reset       (reset),
        .in_size     (in_size),
        .init_write  (init_write),
        .write_ready (write_ready),
        .read_ready  (read_ready),
        .out_size    (out_size),
        .in_tdata    (in_tdata),
        .in_tvalid   (in_tvalid),
        .in_tready   (in_tready),
        .out_tdata   (out_tdata),
        .out_tvalid  (out_tvalid),
        .out_tlast   (out_tlast),
        .out_tready  (out_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            stop_run($sformatf("mismatch at %0d ns: %s is %0h, expected %0h",
                               $time, name, got, expected));
        end
    endtask

    // called and returning on a falling edge
    task automatic wait_strobe(input bit read_side);
        int cycles;
        cycles = 0;
        while (read_side ? !read_ready : !write_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run(read_side ? "timed out waiting for read_ready"
                                   : "timed out waiting for write_ready");
            end
        end
    endtask

    task automatic write_frame(input int n, input bit gaps, input bit request_read);
        int  i;
        int  count;
        int  cycles;
        bit  held;
        for (i = 0; i < n; i++) begin
            model[i] = $random(seed);
        end
        model_len = n;
        wait_strobe(1'b0);
        if (request_read) begin
            // both strobes up so the read could be taken too
            check_value("read_ready", read_ready, 1);
        end
        in_size    = size_t'(n);
        init_write = 1'b1;
        out_tready = request_read;
        @(negedge clk);
        init_write = 1'b0;
        out_tready = 1'b0;
        check_value("write_ready", write_ready, 0);
        check_value("read_ready", read_ready, 0);
        check_value("out_size", out_size, n);
        check_value("in_tready", in_tready, 0);
        @(negedge clk);
        check_value("in_tready", in_tready, 1);
        count  = 0;
        cycles = 0;
        held   = 1'b0;
        while (count < n) begin
            // a presented word stays until accepted
            if (!held) begin
                in_tvalid = gaps ? (($random(seed) & 3) != 0) : 1'b1;
                in_tdata  = in_tvalid ? model[count] : data_t'($random(seed));
            end
            held = in_tvalid && !in_tready;
            if (in_tvalid && in_tready) begin
                count++;
            end
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("timed out while writing the frame");
            end
        end
        in_tvalid = 1'b0;
        check_value("in_tready", in_tready, 0);
    endtask

    task automatic read_frame(input bit random_ready);
        int idx;
        int cycles;
        wait_strobe(1'b1);
        check_value("out_size", out_size, model_len);
        // out_tready in idle is the read request
        out_tready = 1'b1;
        idx    = 0;
        cycles = 0;
        while (idx < model_len) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("timed out while reading the frame");
            end
            out_tready = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
            if (out_tvalid && out_tready) begin
                check_value("out_tdata", out_tdata, model[idx]);
                check_value("out_tlast", out_tlast, idx == model_len - 1);
                idx++;
            end
        end
        @(negedge clk);
        out_tready = 1'b0;
        check_value("out_tvalid", out_tvalid, 0);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic idle_refuses_read();
        int i;
        check_value("in_tready", in_tready, 0);
        check_value("out_tvalid", out_tvalid, 0);
        check_value("read_ready", read_ready, 0);
        out_tready = 1'b1;
        wait_strobe(1'b0);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("out_tvalid", out_tvalid, 0);
            check_value("read_ready", read_ready, 0);
        end
        out_tready = 1'b0;
    endtask

    task automatic write_then_read();
        write_frame(37, 1'b0, 1'b0);
        read_frame(1'b0);
    endtask

    task automatic read_under_backpressure();
        write_frame(64, 1'b0, 1'b0);
        read_frame(1'b1);
    endtask

    task automatic write_with_gaps();
        write_frame(50, 1'b1, 1'b0);
        read_frame(1'b0);
    endtask

    task automatic reread_and_replace();
        read_frame(1'b0);
        write_frame(12, 1'b0, 1'b0);
        read_frame(1'b1);
    endtask

    task automatic write_wins_over_read();
        write_frame(20, 1'b1, 1'b1);
        read_frame(1'b1);
    endtask

    initial begin
        reset      = 1'b1;
        in_size    = '0;
        init_write = 1'b0;
        in_tdata   = '0;
        in_tvalid  = 1'b0;
        out_tready = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle_refuses_read();
        write_then_read();
        read_under_backpressure();
        write_with_gaps();
        reread_and_replace();
        write_wins_over_read();
        if (u_frame_buffer_top.u_frame_buffer_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display("protocol assertions failed during the run");
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/frame_buffer_chk.sv
`timescale 1ns/100ps

module frame_buffer_chk
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  write_ready,
    input  logic  read_ready,
    input  logic  in_tready,
    input  data_t out_tdata,
    input  logic  out_tvalid,
    input  logic  out_tlast,
    input  logic  out_tready
);

    // failed assertions so far
    int fail_count = 0;

    //////////////////////////////////////////////////
    // output stream
    //////////////////////////////////////////////////

    // a word on the output holds until the consumer takes it
    output_hold: assert property (@(posedge clk) disable iff (reset)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
    else begin
        $error("output word changed before it was taken");
        fail_count++;
    end

    //////////////////////////////////////////////////
    // one transfer at a time
    //////////////////////////////////////////////////

    one_direction: assert property (@(posedge clk) disable iff (reset)
        !(in_tready && out_tvalid))
    else begin
        $error("input and output streams active together");
        fail_count++;
    end

    // strobes only while both streams are quiet
    strobe_quiet: assert property (@(posedge clk) disable iff (reset)
        (write_ready || read_ready) |-> !(in_tready || out_tvalid))
    else begin
        $error("ready strobe high during a transfer");
        fail_count++;
    end

endmodule

bind frame_buffer_top frame_buffer_chk u_frame_buffer_chk (
    .clk         (clk),
    .reset       (reset),
    .write_ready (write_ready),
    .read_ready  (read_ready),
    .in_tready   (in_tready),
    .out_tdata   (out_tdata),
    .out_tvalid  (out_tvalid),
    .out_tlast   (out_tlast),
    .out_tready  (out_tready)
);

// File: logic/frame_buffer_top.sv
`timescale 1ns/100ps

module frame_buffer_top
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // frame control
    input  size_t in_size,
    input  logic  init_write,
    output logic  write_ready,
    output logic  read_ready,
    output size_t out_size,

    // producer stream
    input  data_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,

    // consumer stream
    output data_t out_tdata,
    output logic  out_tvalid,
    output logic  out_tlast,
    input  logic  out_tready
);

    // sequencer to movers
    logic  wr_start;
    logic  wr_done;
    logic  rd_start;
    logic  rd_done;

    // movers to ram
    logic  ram_wr_en;
    addr_t ram_wr_addr;
    data_t ram_wr_data;
    logic  ram_rd_en;
    addr_t ram_rd_addr;
    data_t ram_rd_data;

    transfer_sequencer u_transfer_sequencer (
        .clk         (clk),
        .reset       (reset),
        .in_size     (in_size),
        .init_write  (init_write),
        .out_tready  (out_tready),
        .wr_done     (wr_done),
        .rd_done     (rd_done),
        .write_ready (write_ready),
        .read_ready  (read_ready),
        .out_size    (out_size),
        .wr_start    (wr_start),
        .rd_start    (rd_start)
    );

    stream_to_mem u_stream_to_mem (
        .clk         (clk),
        .reset       (reset),
        .wr_start    (wr_start),
        .out_size    (out_size),
        .in_tdata    (in_tdata),
        .in_tvalid   (in_tvalid),
        .in_tready   (in_tready),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .wr_done     (wr_done)
    );

    mem_to_stream u_mem_to_stream (
        .clk         (clk),
        .reset       (reset),
        .rd_start    (rd_start),
        .out_size    (out_size),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data),
        .out_tdata   (out_tdata),
        .out_tvalid  (out_tvalid),
        .out_tlast   (out_tlast),
        .out_tready  (out_tready),
        .rd_done     (rd_done)
    );

    frame_ram u_frame_ram (
        .clk         (clk),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data)
    );

endmodule

// File: logic/transfer_sequencer.sv
`timescale 1ns/100ps

module transfer_sequencer
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  size_t in_size,
    input  logic  init_write,
    input  logic  out_tready,
    input  logic  wr_done,
    input  logic  rd_done,
    output logic  write_ready,
    output logic  read_ready,
    output size_t out_size,
    output logic  wr_start,
    output logic  rd_start
);

    typedef enum logic [2:0] {
        IDLE,
        WR_START,
        WR_DATA,
        RD_START,
        RD_DATA
    } state_t;

    state_t state;
    state_t next_state;
    logic   write_ready_reg;
    logic   read_ready_reg;
    logic   written;
    logic   wr_accept;
    logic   rd_accept;

    // a pending write always wins over a read
    assign wr_accept = (state == IDLE) && init_write && write_ready;
    assign rd_accept = (state == IDLE) && !wr_accept && out_tready && read_ready;

    assign write_ready = write_ready_reg;
    assign read_ready  = read_ready_reg && (written || !WRITE_BEFORE_READ);

    // one cycle start pulses, the start states last a single cycle
    assign wr_start = (state == WR_START);
    assign rd_start = (state == RD_START);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (wr_accept) begin
                    next_state = WR_START;
                end else if (rd_accept) begin
                    next_state = RD_START;
                end
            end
            WR_START: next_state = WR_DATA;
            WR_DATA: begin
                if (wr_done) begin
                    next_state = IDLE;
                end
            end
            RD_START: next_state = RD_DATA;
            RD_DATA: begin
                if (rd_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // strobes, written flag and size
    //////////////////////////////////////////////////

    // strobes drop right away once a transfer is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            write_ready_reg <= 1'b0;
            read_ready_reg  <= 1'b0;
            written         <= 1'b0;
            out_size        <= '0;
        end else begin
            write_ready_reg <= (state == IDLE) && !wr_accept && !rd_accept;
            read_ready_reg  <= (state == IDLE) && !wr_accept && !rd_accept;
            if (state == WR_START) begin
                written <= 1'b1;
            end
            if (wr_accept) begin
                out_size <= in_size;
            end
        end
    end

endmodule

// File: logic/mem_to_stream.sv
`timescale 1ns/100ps

module mem_to_stream
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_start,
    input  size_t out_size,
    output logic  ram_rd_en,
    output addr_t ram_rd_addr,
    input  data_t ram_rd_data,
    output data_t out_tdata,
    output logic  out_tvalid,
    output logic  out_tlast,
    input  logic  out_tready,
    output logic  rd_done
);

    size_t       fetch_count;
    size_t       deliver_count;
    logic        active;
    logic        pend;
    logic        skid_valid;
    data_t       skid_data;
    logic        take;
    logic        last_word;
    logic  [1:0] held;

    assign take      = out_tvalid && out_tready;
    assign last_word = (size_t'(deliver_count + 1'b1) == out_size);
    assign out_tlast = out_tvalid && last_word;

    // words held or on their way from the ram
    assign held = {1'b0, out_tvalid} + {1'b0, skid_valid} + {1'b0, pend};

    // fetch only if the returning word is sure to find a free slot
    assign ram_rd_en   = active && (fetch_count != out_size) &&
                         ((held - {1'b0, take}) <= 2'd1);
    assign ram_rd_addr = fetch_count[ADDR_WIDTH-1:0];

    //////////////////////////////////////////////////
    // fetch and delivery counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            active        <= 1'b0;
            pend          <= 1'b0;
            fetch_count   <= '0;
            deliver_count <= '0;
            rd_done       <= 1'b0;
        end else begin
            pend    <= ram_rd_en;
            rd_done <= take && last_word;
            if (rd_start) begin
                active        <= 1'b1;
                fetch_count   <= '0;
                deliver_count <= '0;
            end else begin
                if (ram_rd_en) begin
                    fetch_count <= fetch_count + 1'b1;
                end
                if (take) begin
                    deliver_count <= deliver_count + 1'b1;
                    if (last_word) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // two slot output buffer
    //////////////////////////////////////////////////

    // output slot refills from the skid slot first, then from the ram
    always_ff @(posedge clk) begin
        if (reset) begin
            out_tvalid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_tvalid || take) begin
            out_tvalid <= skid_valid || pend;
            skid_valid <= skid_valid && pend;
        end else if (pend) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_tvalid || take) begin
            out_tdata <= skid_valid ? skid_data : ram_rd_data;
        end
        // only read back while skid_valid is set
        if (pend) begin
            skid_data <= ram_rd_data;
        end
    end

endmodule

// File: logic/stream_to_mem.sv
`timescale 1ns/100ps

module stream_to_mem
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_start,
    input  size_t out_size,
    input  data_t in_tdata,
    input  logic  in_tvalid,
    output logic  in_tready,
    output logic  ram_wr_en,
    output addr_t ram_wr_addr,
    output data_t ram_wr_data,
    output logic  wr_done
);

    size_t word_count;
    logic  accept;
    logic  last_word;

    assign accept    = in_tvalid && in_tready;
    assign last_word = (size_t'(word_count + 1'b1) == out_size);

    // every accepted word goes straight into the ram
    assign ram_wr_en   = accept;
    assign ram_wr_addr = word_count[ADDR_WIDTH-1:0];
    assign ram_wr_data = in_tdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_tready  <= 1'b0;
            word_count <= '0;
            wr_done    <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                in_tready  <= 1'b1;
                word_count <= '0;
            end else if (accept) begin
                word_count <= word_count + 1'b1;
                // frame complete, close the input
                if (last_word) begin
                    in_tready <= 1'b0;
                    wr_done   <= 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/frame_ram.sv
`timescale 1ns/100ps

module frame_ram
    import frame_buffer_pkg::*;
(
    input  logic  clk,
    input  logic  ram_wr_en,
    input  addr_t ram_wr_addr,
    input  data_t ram_wr_data,
    input  logic  ram_rd_en,
    input  addr_t ram_rd_addr,
    output data_t ram_rd_data
);

    data_t mem [FRAME_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (ram_wr_en) begin
            mem[ram_wr_addr] <= ram_wr_data;
        end
    end

    // read port, data one cycle after the enable
    always_ff @(posedge clk) begin
        if (ram_rd_en) begin
            ram_rd_data <= mem[ram_rd_addr];
        end
    end

endmodule

// File: logic/frame_buffer_pkg.sv
package frame_buffer_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    localparam int DATA_WIDTH  = 32;
    localparam int FRAME_DEPTH = 1024;
    localparam int ADDR_WIDTH  = 10;
    // one more bit than the address, so a full frame fits
    localparam int SIZE_WIDTH  = 11;

    // refuse reads until a frame has been stored
    localparam bit WRITE_BEFORE_READ = 1'b1;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [SIZE_WIDTH-1:0] size_t;

endpackage
